// ==== core_params.svh ====
//****************************
// Core sizing parameters
// Data width, register count and
// register index width shared by
// every stage of the datapath
//****************************
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// Data and instruction word width
`define CORE_DATA_W 16

// Register file depth
`define CORE_NUM_REGS 8

`define CORE_REG_IDX_W 3 // log2 of the register count

`endif

// ==== isa_pkg.sv ====
//****************************
// Instruction set definitions
// Opcodes, R-type function codes and
// the bit positions of the fields
//****************************
package isa_pkg;

   typedef enum logic [3:0] {
      OP_RTYPE = 4'h0,  // Function in bits 2..0
      OP_ADDI  = 4'h1,
      OP_SUBI  = 4'h2,
      OP_ANDI  = 4'h3,
      OP_LUI   = 4'h4,  // Byte goes to the upper half
      OP_BEQZ  = 4'h5,
      OP_BNEZ  = 4'h6,
      OP_BLTZ  = 4'h7,
      OP_BGEZ  = 4'h8,
      OP_J     = 4'h9,
      OP_JR    = 4'hA   // Register plus 6-bit immediate
   } opcode_t;

   typedef enum logic [2:0] {
      FN_ADD, FN_SUB, FN_AND, FN_OR, FN_XOR, FN_SLL, FN_SRL, FN_SRA
   } funct_t;

   // Low bit of each field
   localparam int unsigned FLD_OPC_LSB = 12;
   localparam int unsigned FLD_RD_LSB  = 9;
   localparam int unsigned FLD_RS1_LSB = 6;
   localparam int unsigned FLD_RS2_LSB = 3;

   // Immediate widths
   localparam int unsigned IMM_I_W   = 6;
   localparam int unsigned IMM_B_W   = 9;   // Halfword offset
   localparam int unsigned IMM_J_W   = 12;  // Halfword offset
   localparam int unsigned IMM_LUI_W = 8;

endpackage

// ==== core_ctrl_pkg.sv ====
//****************************
// Datapath control encodings
// ALU functions and branch
// conditions passed from decode
// to execute
//****************************
package core_ctrl_pkg;

   typedef enum logic [2:0] {
      ALU_ADD,    // Carry-in and inversion apply here
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_SLL,
      ALU_SRL,
      ALU_SRA,
      ALU_PASSB
   } alu_op_t;

   // Tests of the first operand against zero
   typedef enum logic [1:0] {
      BR_EQZ,
      BR_NEZ,
      BR_LTZ,  // Sign bit set
      BR_GEZ   // Sign bit clear
   } br_cond_t;

endpackage

// ==== reg_file.sv ====
//****************************
// Register file
// Eight registers, two read ports
// and one write port, with the
// write value bypassed to reads
//****************************
`timescale 1ns/10ps
`include "core_params.svh"

module reg_file (
   input  logic                       clk,
   input  logic                       rst_n,
   input  logic [`CORE_REG_IDX_W-1:0] rd_idx_a,
   input  logic [`CORE_REG_IDX_W-1:0] rd_idx_b,
   output logic [`CORE_DATA_W-1:0]    rd_data_a,
   output logic [`CORE_DATA_W-1:0]    rd_data_b,
   input  logic                       wb_we,
   input  logic [`CORE_REG_IDX_W-1:0] wb_idx,
   input  logic [`CORE_DATA_W-1:0]    wb_data
);

   logic [`CORE_DATA_W-1:0] regs [`CORE_NUM_REGS];

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int i = 0; i < `CORE_NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (wb_we) begin
         regs[wb_idx] <= wb_data;
      end
   end

   // Write-through so a reader two slots behind sees the new value
   always_comb begin
      if (wb_we && (wb_idx == rd_idx_a))
         rd_data_a = wb_data;
      else
         rd_data_a = regs[rd_idx_a];

      if (wb_we && (wb_idx == rd_idx_b))
         rd_data_b = wb_data;
      else
         rd_data_b = regs[rd_idx_b];
   end

endmodule

// ==== alu.sv ====
//****************************
// 16-bit ALU
// Add with carry-in, logic ops and
// shifts, optional operand inversion,
// zero flag and overflow detection
//****************************
`timescale 1ns/10ps
`include "core_params.svh"

module alu (
   input  logic [`CORE_DATA_W-1:0] in_a,
   input  logic [`CORE_DATA_W-1:0] in_b,
   input  logic                    cin,
   input  core_ctrl_pkg::alu_op_t  op,
   input  logic                    inv_a,
   input  logic                    inv_b,
   input  logic                    sign,   // Signed overflow when set
   output logic [`CORE_DATA_W-1:0] out,
   output logic                    zero,
   output logic                    ofl
);

   import core_ctrl_pkg::*;

   localparam int MSB = `CORE_DATA_W - 1;

   logic [`CORE_DATA_W-1:0] a;
   logic [`CORE_DATA_W-1:0] b;
   logic [`CORE_DATA_W:0]   sum;    // Extra bit holds the carry-out
   logic [3:0]              shamt;
   logic                    s_ofl;

   // Inversion happens ahead of every function
   assign a     = inv_a ? ~in_a : in_a;
   assign b     = inv_b ? ~in_b : in_b;
   assign shamt = b[3:0];

   assign sum = {1'b0, a} + {1'b0, b} + {{`CORE_DATA_W{1'b0}}, cin};

   // Same-sign operands giving a result of the other sign
   assign s_ofl = (a[MSB] == b[MSB]) && (sum[MSB] != a[MSB]);

   always_comb begin
      unique case (op)
         ALU_ADD:   out = sum[MSB:0];
         ALU_AND:   out = a & b;
         ALU_OR:    out = a | b;
         ALU_XOR:   out = a ^ b;
         ALU_SLL:   out = a << shamt;
         ALU_SRL:   out = a >> shamt;
         ALU_SRA:   out = $signed(a) >>> shamt;
         ALU_PASSB: out = b;
         default:   out = '0;
      endcase
   end

   assign zero = (out == '0);

   // Only the adder can overflow
   always_comb begin
      if (op == ALU_ADD)
         ofl = sign ? s_ofl : sum[`CORE_DATA_W];
      else
         ofl = 1'b0;
   end

endmodule

// ==== execute.sv ====
//****************************
// Execute stage
// Forwards the writeback result,
// runs the ALU, resolves branches and
// computes the redirect target
//****************************
`timescale 1ns/10ps
`include "core_params.svh"

module execute (
   input  logic                       ex_valid,
   input  logic [`CORE_DATA_W-1:0]    oprnd_1,
   input  logic [`CORE_DATA_W-1:0]    oprnd_2,
   input  logic [`CORE_REG_IDX_W-1:0] src_a_idx,
   input  logic [`CORE_REG_IDX_W-1:0] src_b_idx,
   input  logic                       fwd_a_en,
   input  logic                       fwd_b_en,
   input  core_ctrl_pkg::alu_op_t     alu_op,
   input  logic                       alu_inv_a,
   input  logic                       alu_inv_b,
   input  logic                       alu_cin,
   input  logic                       br_instr,
   input  core_ctrl_pkg::br_cond_t    br_cond,
   input  logic                       jmp_instr,
   input  logic                       jr_instr,
   input  logic [`CORE_DATA_W-1:0]    ex_imm,
   input  logic [`CORE_DATA_W-1:0]    ex_pc_inc,
   input  logic                       wr_en,
   input  logic [`CORE_REG_IDX_W-1:0] dst_idx,
   input  logic                       wb_we,
   input  logic [`CORE_REG_IDX_W-1:0] wb_idx,
   input  logic [`CORE_DATA_W-1:0]    wb_data,
   output logic [`CORE_DATA_W-1:0]    alu_out,
   output logic                       alu_ofl,
   output logic                       pc_src,     // Redirect requested
   output logic [`CORE_DATA_W-1:0]    pc_target,
   output logic                       res_valid,
   output logic                       res_wr_en,
   output logic [`CORE_REG_IDX_W-1:0] res_dst_idx
);

   import core_ctrl_pkg::*;

   logic [`CORE_DATA_W-1:0] op_a;
   logic [`CORE_DATA_W-1:0] op_b;
   logic                    zero;
   logic                    take_br;

   // Producer one slot ahead sits in the writeback register
   assign op_a = (wb_we && fwd_a_en && (wb_idx == src_a_idx)) ? wb_data : oprnd_1;
   assign op_b = (wb_we && fwd_b_en && (wb_idx == src_b_idx)) ? wb_data : oprnd_2;

   alu u_alu (
      .in_a  (op_a),
      .in_b  (op_b),
      .cin   (alu_cin),
      .op    (alu_op),
      .inv_a (alu_inv_a),
      .inv_b (alu_inv_b),
      .sign  (1'b1),
      .out   (alu_out),
      .zero  (zero),
      .ofl   (alu_ofl)
   );

   // Branches add zero, so the ALU zero flag tests op_a
   always_comb begin
      unique case (br_cond)
         BR_EQZ:  take_br = zero;
         BR_NEZ:  take_br = ~zero;
         BR_LTZ:  take_br = op_a[`CORE_DATA_W-1];
         default: take_br = ~op_a[`CORE_DATA_W-1];
      endcase
   end

   assign pc_src    = ex_valid & (jmp_instr | (br_instr & take_br));
   assign pc_target = jr_instr ? op_a + ex_imm : ex_pc_inc + (ex_imm << 1);

   assign res_valid   = ex_valid;
   assign res_wr_en   = wr_en;
   assign res_dst_idx = dst_idx;

endmodule

// ==== decode.sv ====
//****************************
// Decode stage
// Decodes the instruction, reads the
// register file, extends immediates
// and registers the execute controls
//****************************
`timescale 1ns/10ps
`include "core_params.svh"

module decode (
   input  logic                       clk,
   input  logic                       rst_n,
   input  logic                       instr_valid,
   input  logic [`CORE_DATA_W-1:0]    instr,
   input  logic [`CORE_DATA_W-1:0]    pc_inc,
   output logic [`CORE_REG_IDX_W-1:0] rd_idx_a,
   output logic [`CORE_REG_IDX_W-1:0] rd_idx_b,
   input  logic [`CORE_DATA_W-1:0]    rd_data_a,
   input  logic [`CORE_DATA_W-1:0]    rd_data_b,
   output logic                       ex_valid,
   output logic [`CORE_DATA_W-1:0]    oprnd_1,
   output logic [`CORE_DATA_W-1:0]    oprnd_2,
   output logic [`CORE_REG_IDX_W-1:0] src_a_idx,
   output logic [`CORE_REG_IDX_W-1:0] src_b_idx,
   output logic                       fwd_a_en,
   output logic                       fwd_b_en,
   output core_ctrl_pkg::alu_op_t     alu_op,
   output logic                       alu_inv_a,
   output logic                       alu_inv_b,
   output logic                       alu_cin,
   output logic                       br_instr,
   output core_ctrl_pkg::br_cond_t    br_cond,
   output logic                       jmp_instr,
   output logic                       jr_instr,
   output logic [`CORE_DATA_W-1:0]    ex_imm,
   output logic [`CORE_DATA_W-1:0]    ex_pc_inc,
   output logic                       wr_en,
   output logic [`CORE_REG_IDX_W-1:0] dst_idx,
   output logic                       err
);

   import isa_pkg::*;
   import core_ctrl_pkg::*;

   localparam int DW = `CORE_DATA_W;

   opcode_t          opc;
   funct_t           fn;
   logic [DW-1:0]    imm_i, imm_b, imm_j, imm_lui;
   logic [DW-1:0]    imm, op2_imm;
   logic             illegal, is_br, is_jmp, is_jr, we, use_ra, use_rb;
   alu_op_t          op;
   logic             inv_b, cin;
   br_cond_t         cond;

   assign opc = opcode_t'(instr[FLD_OPC_LSB +: 4]);
   assign fn  = funct_t'(instr[2:0]);

   assign imm_i   = {{(DW-IMM_I_W){instr[IMM_I_W-1]}}, instr[IMM_I_W-1:0]};
   assign imm_b   = {{(DW-IMM_B_W){instr[IMM_B_W-1]}}, instr[IMM_B_W-1:0]};
   assign imm_j   = {{(DW-IMM_J_W){instr[IMM_J_W-1]}}, instr[IMM_J_W-1:0]};
   assign imm_lui = {instr[IMM_LUI_W-1:0], {(DW-IMM_LUI_W){1'b0}}};

   always_comb begin
      illegal = 1'b0;
      is_br   = 1'b0;
      is_jmp  = 1'b0;
      is_jr   = 1'b0;
      we      = 1'b0;
      use_ra  = 1'b0;
      use_rb  = 1'b0;
      op      = ALU_ADD;
      inv_b   = 1'b0;
      cin     = 1'b0;
      cond    = BR_EQZ;
      imm     = imm_i;
      op2_imm = imm_i;
      unique case (opc)
         OP_RTYPE: begin
            {we, use_ra, use_rb} = 3'b111;
            unique case (fn)
               FN_SUB: {inv_b, cin} = 2'b11;   // A + ~B + 1
               FN_AND: op = ALU_AND;
               FN_OR:  op = ALU_OR;
               FN_XOR: op = ALU_XOR;
               FN_SLL: op = ALU_SLL;
               FN_SRL: op = ALU_SRL;
               FN_SRA: op = ALU_SRA;
               default: op = ALU_ADD;
            endcase
         end
         OP_ADDI: {we, use_ra} = 2'b11;
         OP_SUBI: {we, use_ra, inv_b, cin} = 4'b1111;
         OP_ANDI: begin
            {we, use_ra} = 2'b11;
            op = ALU_AND;
         end
         OP_LUI: begin
            we      = 1'b1;
            op      = ALU_PASSB;
            op2_imm = imm_lui;
         end
         OP_BEQZ, OP_BNEZ, OP_BLTZ, OP_BGEZ: begin
            {is_br, use_ra} = 2'b11;
            imm     = imm_b;
            op2_imm = '0;                      // ALU zero flag tests the register
            if (opc == OP_BNEZ)      cond = BR_NEZ;
            else if (opc == OP_BLTZ) cond = BR_LTZ;
            else if (opc == OP_BGEZ) cond = BR_GEZ;
         end
         OP_J: begin
            is_jmp = 1'b1;
            imm    = imm_j;
         end
         OP_JR:   {is_jmp, is_jr, use_ra} = 3'b111;
         default: illegal = 1'b1;
      endcase
   end

   // Branches keep their register in the destination field
   assign rd_idx_a = is_br ? instr[FLD_RD_LSB +: `CORE_REG_IDX_W]
                           : instr[FLD_RS1_LSB +: `CORE_REG_IDX_W];
   assign rd_idx_b = instr[FLD_RS2_LSB +: `CORE_REG_IDX_W];

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         ex_valid <= 1'b0;
         err      <= 1'b0;
      end else begin
         ex_valid <= instr_valid & ~illegal;
         err      <= instr_valid & illegal;   // One-cycle pulse
      end
   end

   // Pipeline register, loaded only on an accepted instruction
   always_ff @(posedge clk) begin
      if (instr_valid) begin
         oprnd_1   <= rd_data_a;
         oprnd_2   <= use_rb ? rd_data_b : op2_imm;
         src_a_idx <= rd_idx_a;
         src_b_idx <= rd_idx_b;
         fwd_a_en  <= use_ra;
         fwd_b_en  <= use_rb;
         alu_op    <= op;
         alu_inv_a <= 1'b0;                   // No instruction inverts A
         alu_inv_b <= inv_b;
         alu_cin   <= cin;
         br_instr  <= is_br;
         br_cond   <= cond;
         jmp_instr <= is_jmp;
         jr_instr  <= is_jr;
         ex_imm    <= imm;
         ex_pc_inc <= pc_inc;
         wr_en     <= we;
         dst_idx   <= instr[FLD_RD_LSB +: `CORE_REG_IDX_W];
      end
   end

endmodule

// ==== writeback.sv ====
//****************************
// Writeback stage
// Registers the execute result and
// drives the register write and the
// control-flow redirect
//****************************
`timescale 1ns/10ps
`include "core_params.svh"

module writeback (
   input  logic                       clk,
   input  logic                       rst_n,
   input  logic                       ex_valid,
   input  logic                       wr_en,
   input  logic [`CORE_REG_IDX_W-1:0] dst_idx,
   input  logic [`CORE_DATA_W-1:0]    alu_out,
   input  logic                       alu_ofl,
   input  logic                       pc_src,
   input  logic [`CORE_DATA_W-1:0]    pc_target,
   output logic                       wb_valid,
   output logic                       wb_we,
   output logic [`CORE_REG_IDX_W-1:0] wb_idx,
   output logic [`CORE_DATA_W-1:0]    wb_data,
   output logic                       ofl,
   output logic                       redirect,
   output logic [`CORE_DATA_W-1:0]    redirect_pc
);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wb_valid    <= 1'b0;
         wb_we       <= 1'b0;
         wb_idx      <= '0;
         wb_data     <= '0;
         ofl         <= 1'b0;
         redirect    <= 1'b0;
         redirect_pc <= '0;
      end else begin
         wb_valid    <= ex_valid;
         wb_we       <= ex_valid & wr_en;
         wb_idx      <= dst_idx;
         wb_data     <= alu_out;
         ofl         <= ex_valid & wr_en & alu_ofl;  // Only for register writers
         redirect    <= ex_valid & pc_src;
         redirect_pc <= pc_target;
      end
   end

endmodule

// ==== core_top.sv ====
//****************************
// Datapath core top level
// Decode, register file, execute
// and writeback of the 16-bit core
//****************************
`timescale 1ns/10ps
`include "core_params.svh"

module core_top (
   input  logic                       clk,
   input  logic                       rst_n,
   input  logic                       instr_valid,
   input  logic [`CORE_DATA_W-1:0]    instr,
   input  logic [`CORE_DATA_W-1:0]    pc_inc,
   output logic                       wb_valid,
   output logic                       wb_we,
   output logic [`CORE_REG_IDX_W-1:0] wb_idx,
   output logic [`CORE_DATA_W-1:0]    wb_data,
   output logic                       ofl,
   output logic                       redirect,
   output logic [`CORE_DATA_W-1:0]    redirect_pc,
   output logic                       err
);

   import core_ctrl_pkg::*;

   logic [`CORE_REG_IDX_W-1:0] rd_idx_a, rd_idx_b, src_a_idx, src_b_idx, dst_idx;
   logic [`CORE_DATA_W-1:0]    rd_data_a, rd_data_b, oprnd_1, oprnd_2;
   logic [`CORE_DATA_W-1:0]    ex_imm, ex_pc_inc, alu_out, pc_target;
   logic                       ex_valid, fwd_a_en, fwd_b_en, wr_en;
   logic                       alu_inv_a, alu_inv_b, alu_cin;
   logic                       br_instr, jmp_instr, jr_instr;
   logic                       alu_ofl, pc_src, res_valid, res_wr_en;
   logic [`CORE_REG_IDX_W-1:0] res_dst_idx;
   alu_op_t                    alu_op;
   br_cond_t                   br_cond;

   decode u_decode (.*);

   reg_file u_reg_file (.*);  // Written from the writeback register

   execute u_execute (.*);

   writeback u_writeback (
      .clk         (clk),
      .rst_n       (rst_n),
      .ex_valid    (res_valid),
      .wr_en       (res_wr_en),
      .dst_idx     (res_dst_idx),
      .alu_out     (alu_out),
      .alu_ofl     (alu_ofl),
      .pc_src      (pc_src),
      .pc_target   (pc_target),
      .wb_valid    (wb_valid),
      .wb_we       (wb_we),
      .wb_idx      (wb_idx),
      .wb_data     (wb_data),
      .ofl         (ofl),
      .redirect    (redirect),
      .redirect_pc (redirect_pc)
   );

endmodule

// ==== tb_core_top.sv ====
//******************************
// Datapath core testbench
// Applies a table of instructions and
// checks writeback, overflow, redirect
// and err against a register model
//******************************
`timescale 1ns/10ps
`include "core_params.svh"

module tb_core_top;

   import isa_pkg::*;
   import core_ctrl_pkg::*;

   localparam int DW         = `CORE_DATA_W;
   localparam int CLK_HALF   = 2;
   localparam int CLK_PERIOD = 2 * CLK_HALF;
   localparam int RST_CYCLES = 5;
   localparam int N_RAND     = 40;
   localparam int TBL_MAX    = 128;
   localparam int WD_MARGIN  = 20;   // Slack cycles for the watchdog

   logic                       clk;
   logic                       rst_n;
   logic                       instr_valid;
   logic [DW-1:0]              instr;
   logic [DW-1:0]              pc_inc;
   logic                       wb_valid, wb_we, ofl, redirect, err;
   logic [`CORE_REG_IDX_W-1:0] wb_idx;
   logic [DW-1:0]              wb_data, redirect_pc;

   // Stimulus columns
   logic [DW-1:0] tbl_instr [TBL_MAX];
   logic [DW-1:0] tbl_pc    [TBL_MAX];
   // Expected columns, filled in by the model
   logic          exp_valid [TBL_MAX];
   logic          exp_we    [TBL_MAX];
   logic [2:0]    exp_idx   [TBL_MAX];
   logic [DW-1:0] exp_data  [TBL_MAX];
   logic          exp_ofl   [TBL_MAX];
   logic          exp_redir [TBL_MAX];
   logic [DW-1:0] exp_tgt   [TBL_MAX];
   logic          exp_err   [TBL_MAX];

   logic [DW-1:0] model_regs [`CORE_NUM_REGS];
   logic [DW-1:0] next_pc;
   int            tbl_len;
   int            errors;
   int            checks;
   logic          tbl_ready;

   core_top UUT (
      .clk         (clk),
      .rst_n       (rst_n),
      .instr_valid (instr_valid),
      .instr       (instr),
      .pc_inc      (pc_inc),
      .wb_valid    (wb_valid),
      .wb_we       (wb_we),
      .wb_idx      (wb_idx),
      .wb_data     (wb_data),
      .ofl         (ofl),
      .redirect    (redirect),
      .redirect_pc (redirect_pc),
      .err         (err)
   );

   initial clk = 1'b0;
   always #CLK_HALF clk = ~clk;

   task automatic check_val(input string name, input logic [DW-1:0] got,
                            input logic [DW-1:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Mismatch at %0d ns: %s is %h, expected %h", $time, name, got, exp);
      end
   endtask

   // Instruction word builders
   function automatic logic [DW-1:0] r_word(funct_t fn, int rd, int rs1, int rs2);
      return {OP_RTYPE, rd[2:0], rs1[2:0], rs2[2:0], fn};
   endfunction

   function automatic logic [DW-1:0] i_word(opcode_t op, int rd, int rs1, int imm);
      return {op, rd[2:0], rs1[2:0], imm[5:0]};
   endfunction

   function automatic logic [DW-1:0] lui_word(int rd, int imm);
      return {OP_LUI, rd[2:0], 1'b0, imm[7:0]};
   endfunction

   function automatic logic [DW-1:0] br_word(opcode_t op, int rs, int off);
      return {op, rs[2:0], off[8:0]};
   endfunction

   function automatic logic [DW-1:0] j_word(int off);
      return {OP_J, off[11:0]};
   endfunction

   task automatic add_instr(input logic [DW-1:0] w);
      tbl_instr[tbl_len] = w;
      tbl_pc[tbl_len]    = next_pc;
      next_pc            = next_pc + 16'd2;
      tbl_len++;
   endtask

   // Random R-type and I-type words, LUI included
   task automatic add_random(input int count);
      logic [31:0] rnd;
      logic [3:0]  opc;
      for (int i = 0; i < count; i++) begin
         rnd = $urandom;
         opc = 4'($urandom_range(4, 0));
         add_instr({opc, rnd[11:0]});
      end
   endtask

   task automatic build_table();
      tbl_len = 0;
      next_pc = 16'h0102;
      add_instr(lui_word(1, 'h7F));
      add_instr(i_word(OP_ADDI, 1, 1, 31));     // Back-to-back on r1
      add_instr(lui_word(2, 'h80));
      add_instr(r_word(FN_ADD, 3, 1, 1));        // Overflow, r1 two slots back
      add_instr(r_word(FN_SUB, 4, 2, 1));        // Overflow
      add_instr(r_word(FN_ADD, 5, 4, 3));
      add_instr(r_word(FN_AND, 6, 5, 1));
      add_instr(r_word(FN_OR, 7, 6, 2));
      add_instr(r_word(FN_XOR, 0, 7, 1));
      add_instr(i_word(OP_SUBI, 0, 0, 1));
      add_instr(i_word(OP_ANDI, 6, 5, -3));
      add_instr(i_word(OP_SUBI, 2, 2, 1));       // 0x8000 minus one overflows
      // Shift counts 0, 15, 7 and 33
      add_instr(lui_word(7, 0));
      add_instr(r_word(FN_SLL, 4, 3, 7));
      add_instr(i_word(OP_ADDI, 7, 7, 15));
      add_instr(r_word(FN_SRA, 4, 3, 7));
      add_instr(r_word(FN_SRL, 5, 3, 7));
      add_instr(r_word(FN_SLL, 6, 1, 7));
      add_instr(i_word(OP_ADDI, 7, 7, -8));
      add_instr(r_word(FN_SLL, 5, 1, 7));
      add_instr(r_word(FN_SRA, 6, 3, 7));
      add_instr(r_word(FN_SRL, 6, 3, 7));
      add_instr(i_word(OP_ADDI, 7, 7, 26));
      add_instr(r_word(FN_SRA, 4, 3, 7));
      // Branches on zero, positive and negative registers
      add_instr(lui_word(0, 0));
      add_instr(br_word(OP_BEQZ, 0, 5));
      add_instr(br_word(OP_BNEZ, 0, -3));
      add_instr(br_word(OP_BLTZ, 0, 7));
      add_instr(br_word(OP_BGEZ, 0, -100));
      add_instr(i_word(OP_ADDI, 1, 0, 12));
      add_instr(br_word(OP_BEQZ, 1, 10));
      add_instr(br_word(OP_BNEZ, 1, -1));
      add_instr(br_word(OP_BLTZ, 1, 2));
      add_instr(br_word(OP_BGEZ, 1, 255));
      add_instr(i_word(OP_SUBI, 2, 0, 5));
      add_instr(br_word(OP_BLTZ, 2, -256));
      add_instr(br_word(OP_BGEZ, 2, 3));
      add_instr(br_word(OP_BEQZ, 2, 1));
      add_instr(br_word(OP_BNEZ, 2, 4));
      add_instr(j_word(2047));
      add_instr(j_word(-2048));
      add_instr(lui_word(3, 'h12));
      add_instr(i_word(OP_JR, 3, 3, -4));        // Register written one slot back
      add_instr(i_word(OP_ADDI, 3, 3, 6));       // JR must leave r3 alone
      add_instr(i_word(OP_JR, 0, 3, 31));
      // Illegal words sit between a writer of r5 and its reader
      add_instr(lui_word(5, 'h33));
      add_instr({4'hB, 12'hA49});
      add_instr({4'hF, 12'hFFF});
      add_instr(r_word(FN_ADD, 6, 5, 5));
      add_random(N_RAND);
   endtask

   task automatic alu_result(input logic [2:0] fn, input logic [DW-1:0] a,
                             input logic [DW-1:0] b, output logic [DW-1:0] r,
                             output logic v);
      v = 1'b0;
      case (fn)
         FN_ADD: begin
            r = a + b;
            v = (a[DW-1] == b[DW-1]) && (r[DW-1] != a[DW-1]);
         end
         FN_SUB: begin
            r = a - b;
            v = (a[DW-1] != b[DW-1]) && (r[DW-1] != a[DW-1]);
         end
         FN_AND:  r = a & b;
         FN_OR:   r = a | b;
         FN_XOR:  r = a ^ b;
         FN_SLL:  r = a << b[3:0];
         FN_SRL:  r = a >> b[3:0];
         default: r = $signed(a) >>> b[3:0];
      endcase
   endtask

   // Executes one table entry in program order on the model registers
   task automatic model_entry(input int n);
      logic [DW-1:0] w, a, r, imm6, off9, off12;
      logic [2:0]    rd;
      logic          v, take, writes;
      w     = tbl_instr[n];
      rd    = w[11:9];
      a     = model_regs[w[8:6]];
      imm6  = {{(DW-6){w[5]}}, w[5:0]};
      off9  = {{(DW-9){w[8]}}, w[8:0]};
      off12 = {{(DW-12){w[11]}}, w[11:0]};
      r     = '0;
      v     = 1'b0;
      take  = 1'b0;
      exp_valid[n] = 1'b1;
      exp_err[n]   = 1'b0;
      case (w[15:12])
         OP_RTYPE:    alu_result(w[2:0], a, model_regs[w[5:3]], r, v);
         OP_ADDI:     alu_result(FN_ADD, a, imm6, r, v);
         OP_SUBI:     alu_result(FN_SUB, a, imm6, r, v);
         OP_ANDI:     alu_result(FN_AND, a, imm6, r, v);
         OP_LUI:      r = {w[7:0], 8'h00};
         OP_BEQZ:     take = (model_regs[rd] == '0);
         OP_BNEZ:     take = (model_regs[rd] != '0);
         OP_BLTZ:     take = model_regs[rd][DW-1];
         OP_BGEZ:     take = !model_regs[rd][DW-1];
         OP_J, OP_JR: take = 1'b1;
         default: begin
            exp_valid[n] = 1'b0;
            exp_err[n]   = 1'b1;
         end
      endcase
      writes       = w[15:12] inside {OP_RTYPE, OP_ADDI, OP_SUBI, OP_ANDI, OP_LUI};
      exp_we[n]    = writes;
      exp_idx[n]   = rd;
      exp_data[n]  = r;
      exp_ofl[n]   = writes & v;
      exp_redir[n] = take;
      if (writes)
         model_regs[rd] = r;
      if (w[15:12] == OP_JR)
         exp_tgt[n] = a + imm6;
      else if (w[15:12] == OP_J)
         exp_tgt[n] = tbl_pc[n] + (off12 << 1);
      else
         exp_tgt[n] = tbl_pc[n] + (off9 << 1);
   endtask

   task automatic check_wb(input int n);
      check_val("wb_valid", DW'(wb_valid), DW'(exp_valid[n]));
      check_val("wb_we", DW'(wb_we), DW'(exp_we[n]));
      check_val("ofl", DW'(ofl), DW'(exp_ofl[n]));
      check_val("redirect", DW'(redirect), DW'(exp_redir[n]));
      if (exp_we[n]) begin
         check_val("wb_idx", DW'(wb_idx), DW'(exp_idx[n]));
         check_val("wb_data", wb_data, exp_data[n]);
      end
      if (exp_redir[n])
         check_val("redirect_pc", redirect_pc, exp_tgt[n]);
   endtask

   initial begin
      errors      = 0;
      checks      = 0;
      tbl_ready   = 1'b0;
      rst_n       = 1'b0;
      instr_valid = 1'b0;
      instr       = '0;
      pc_inc      = '0;
      void'($urandom(32'h4643));
      for (int i = 0; i < `CORE_NUM_REGS; i++)
         model_regs[i] = '0;
      build_table();
      for (int i = 0; i < tbl_len; i++)
         model_entry(i);
      tbl_ready = 1'b1;
      repeat (RST_CYCLES) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      check_val("wb_valid", DW'(wb_valid), '0);   // Idle right after reset
      check_val("wb_we", DW'(wb_we), '0);
      check_val("redirect", DW'(redirect), '0);
      check_val("err", DW'(err), '0);
      // Slot s drives entry s, sees err of s-1 and writeback of s-2
      for (int s = 0; s < tbl_len + 2; s++) begin
         if (s >= 2)
            check_wb(s - 2);
         if (s >= 1 && s <= tbl_len)
            check_val("err", DW'(err), DW'(exp_err[s-1]));
         if (s < tbl_len) begin
            instr_valid = 1'b1;
            instr       = tbl_instr[s];
            pc_inc      = tbl_pc[s];
         end else begin
            instr_valid = 1'b0;
            instr       = '0;
         end
         @(negedge clk);
      end
      $display("Closing count: %0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

   // Watchdog sized from the table length
   initial begin
      wait (tbl_ready);
      #((RST_CYCLES + tbl_len + 2 + WD_MARGIN) * CLK_PERIOD);
      $display("Timeout: the instruction table did not complete in the expected time");
      $display("Checks failed");
      $finish;
   end

endmodule

// ==== filelist.f ====
+incdir+.
isa_pkg.sv
core_ctrl_pkg.sv
reg_file.sv
alu.sv
execute.sv
decode.sv
writeback.sv
core_top.sv
tb_core_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the core testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_core_top -f filelist.f -o tb_core_top
./obj_dir/tb_core_top | tee sim.log

if grep -q "All checks passed" sim.log; then
   echo "Simulation result: PASS"
else
   echo "Simulation result: FAIL"
   exit 1
fi
